// ==== logic/dsp_pkg.sv ====
// dsp package: shared sample and accumulator widths, baseband source codes, buffer word
`default_nettype none

package dsp_pkg;

	// adc, dac and lo samples, signed two's complement
	localparam int sample_w = 16;

	// one accumulator, wide enough for a full product
	// running sums wrap modulo 2^acc_w
	localparam int acc_w = 32;

	// baseband source select codes, as seen on bb_sel
	// adc word of the lane
	localparam logic [1:0] src_adc = 2'd0;
	// first dac monitor word
	localparam logic [1:0] src_dac_a = 2'd1;
	// second dac monitor word
	localparam logic [1:0] src_dac_b = 2'd2;
	// no source, lane integrates zero
	localparam logic [1:0] src_zero = 2'd3;

	// accumulation buffer word
	// writer fills the x/y pair, the buffer port sees the raw word
	typedef union packed {
		struct packed {
			// x accumulator in the upper half
			logic [acc_w-1:0] acc_x;
			// y accumulator in the lower half
			logic [acc_w-1:0] acc_y;
		} pair;
		logic [2*acc_w-1:0] raw;
	} acc_word_t;

endpackage

`default_nettype wire

// ==== logic/shot_sequencer.sv ====
// shot sequencer repeating run and drain phases with the cores reset between shots
`default_nettype none
`timescale 1ns/1ps

module shot_sequencer (
	input wire dspif,
	input wire reset,
	input wire stb_start,
	input wire [31:0] nshot,
	input wire all_done,
	input wire all_idle,
	output logic proc_reset,
	output logic [31:0] shot_count,
	output logic lastshot_done
);

	// state codes walk the shot loop in gray-like steps
	localparam logic [3:0] idle = 4'b0000;
	localparam logic [3:0] start = 4'b0001;
	localparam logic [3:0] procrun = 4'b0011;
	localparam logic [3:0] elembusy = 4'b0010;
	localparam logic [3:0] moreshot = 4'b0110;
	localparam logic [3:0] shotadd = 4'b0111;
	localparam logic [3:0] done = 4'b0101;

	logic [3:0] state;
	logic [3:0] nextstate;
	// shot count latched at the start of the sequence
	logic [31:0] nshot_r;
	// running shot index and its precomputed successor
	logic [31:0] shot_cnt;
	logic [31:0] next_cnt;
	logic more_shot;
	// second register stage on the core status levels
	logic done_r;
	logic idle_r;

	always_ff @(posedge dspif) begin
		if (reset) begin
			state <= idle;
		end else begin
			state <= nextstate;
		end
	end

	always_comb begin
		nextstate = idle;
		case (state)
			idle: nextstate = stb_start ? start : idle;
			start: nextstate = procrun;
			// cores running until every one reports done
			procrun: nextstate = done_r ? elembusy : procrun;
			// drain waits for all elements to go idle
			elembusy: nextstate = idle_r ? moreshot : elembusy;
			moreshot: nextstate = more_shot ? shotadd : done;
			shotadd: nextstate = start;
			done: nextstate = idle;
			default: nextstate = idle;
		endcase
	end

	// count compare kept off the state decode path
	// settles long before the next moreshot
	always_ff @(posedge dspif) begin
		next_cnt <= shot_cnt + 32'd1;
		// nshot of zero means run forever
		more_shot <= (next_cnt != nshot_r) | (nshot_r == 32'd0);
		done_r <= all_done;
		idle_r <= all_idle;
		if (nextstate == idle) begin
			nshot_r <= nshot;
		end
	end

	// outputs registered from the next state
	always_ff @(posedge dspif) begin
		if (reset) begin
			shot_cnt <= 32'd0;
			shot_count <= 32'd0;
			lastshot_done <= 1'b0;
			proc_reset <= 1'b1;
		end else begin
			lastshot_done <= 1'b0;
			proc_reset <= 1'b1;
			case (nextstate)
				idle: shot_cnt <= 32'd0;
				// cores released only while running
				procrun: proc_reset <= 1'b0;
				shotadd: begin
					shot_cnt <= next_cnt;
					// report the shot just finished
					shot_count <= shot_cnt;
				end
				done: begin
					// last shot also gets reported
					shot_count <= shot_cnt;
					shot_cnt <= 32'd0;
					lastshot_done <= 1'b1;
				end
				default: shot_cnt <= shot_cnt;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/readout_lane.sv ====
// readout lane: baseband source select, complex lo multiply, gated x/y accumulation
`default_nettype none
`timescale 1ns/1ps

module readout_lane
	import dsp_pkg::*;
(
	input wire dspif,
	input wire reset,
	input wire [sample_w-1:0] adc,
	input wire [sample_w-1:0] dac_a,
	input wire [sample_w-1:0] dac_b,
	input wire [1:0] bb_sel,
	input wire [sample_w-1:0] lo_x,
	input wire [sample_w-1:0] lo_y,
	input wire gate,
	output logic [acc_w-1:0] acc_x,
	output logic [acc_w-1:0] acc_y,
	output logic acc_stb
);

	// stage 1, selected sample and matching lo
	logic signed [sample_w-1:0] bb;
	logic signed [sample_w-1:0] lo_x_r;
	logic signed [sample_w-1:0] lo_y_r;
	// stage 2, full width products
	logic signed [acc_w-1:0] prod_x;
	logic signed [acc_w-1:0] prod_y;
	// gate delayed to line up with the products, plus one for edge detect
	logic [2:0] gate_d;
	logic first;

	always_ff @(posedge dspif) begin
		case (bb_sel)
			src_adc: bb <= adc;
			src_dac_a: bb <= dac_a;
			src_dac_b: bb <= dac_b;
			src_zero: bb <= '0;
			default: bb <= '0;
		endcase
		lo_x_r <= lo_x;
		lo_y_r <= lo_y;
	end

	always_ff @(posedge dspif) begin
		prod_x <= bb * lo_x_r;
		prod_y <= bb * lo_y_r;
	end

	always_ff @(posedge dspif) begin
		if (reset) begin
			gate_d <= 3'b000;
		end else begin
			gate_d <= {gate_d[1:0], gate};
		end
	end

	// first product of a window loads instead of adding
	assign first = gate_d[1] & ~gate_d[2];

	always_ff @(posedge dspif) begin
		if (gate_d[1]) begin
			if (first) begin
				acc_x <= prod_x;
				acc_y <= prod_y;
			end else begin
				// wraps modulo 2^acc_w
				acc_x <= acc_x + prod_x;
				acc_y <= acc_y + prod_y;
			end
		end
	end

	// falling edge of the aligned gate, sums are final
	always_ff @(posedge dspif) begin
		if (reset) begin
			acc_stb <= 1'b0;
		end else begin
			acc_stb <= gate_d[2] & ~gate_d[1];
		end
	end

endmodule

`default_nettype wire

// ==== logic/accbuf_writer.sv ====
// accumulation buffer writer: turns lane results into buffer writes with locking addresses
`default_nettype none
`timescale 1ns/1ps

module accbuf_writer
	import dsp_pkg::*;
#(
	parameter int accbuf_addr_w = 4
) (
	input wire dspif,
	input wire reset,
	input wire resetacc,
	input wire [acc_w-1:0] acc_x0,
	input wire [acc_w-1:0] acc_y0,
	input wire acc_stb0,
	input wire [acc_w-1:0] acc_x1,
	input wire [acc_w-1:0] acc_y1,
	input wire acc_stb1,
	output logic accbuf_we0,
	output logic accbuf_we1,
	output logic [accbuf_addr_w-1:0] accbuf_addr0,
	output logic [accbuf_addr_w-1:0] accbuf_addr1,
	output logic [2*acc_w-1:0] accbuf_data0,
	output logic [2*acc_w-1:0] accbuf_data1
);

	// lane inputs gathered so both lanes share one body
	logic [acc_w-1:0] lane_x [2];
	logic [acc_w-1:0] lane_y [2];
	logic lane_stb [2];
	logic resetacc_r;
	logic we [2];
	logic [accbuf_addr_w-1:0] addr [2];
	acc_word_t word [2];

	assign lane_x[0] = acc_x0;
	assign lane_y[0] = acc_y0;
	assign lane_stb[0] = acc_stb0;
	assign lane_x[1] = acc_x1;
	assign lane_y[1] = acc_y1;
	assign lane_stb[1] = acc_stb1;

	// level clear, registered once, applies to both lanes
	always_ff @(posedge dspif) begin
		if (reset) begin
			resetacc_r <= 1'b0;
		end else begin
			resetacc_r <= resetacc;
		end
	end

	for (genvar i = 0; i < 2; i++) begin : g_lane
		always_ff @(posedge dspif) begin
			if (reset) begin
				we[i] <= 1'b0;
			end else begin
				we[i] <= lane_stb[i];
			end
		end

		// data captured with the enable
		always_ff @(posedge dspif) begin
			if (lane_stb[i]) begin
				word[i].pair.acc_x <= lane_x[i];
				word[i].pair.acc_y <= lane_y[i];
			end
		end

		// write uses the current address, then steps
		// sticks at the last location once reached
		always_ff @(posedge dspif) begin
			if (reset || resetacc_r) begin
				addr[i] <= '0;
			end else if (we[i] && !(&addr[i])) begin
				addr[i] <= addr[i] + 1'b1;
			end
		end
	end

	assign accbuf_we0 = we[0];
	assign accbuf_we1 = we[1];
	assign accbuf_addr0 = addr[0];
	assign accbuf_addr1 = addr[1];
	assign accbuf_data0 = word[0].raw;
	assign accbuf_data1 = word[1].raw;

endmodule

`default_nettype wire

// ==== logic/dsp_top.sv ====
// dsp top: shot sequencer, two readout lanes and the accumulation buffer writer
`default_nettype none
`timescale 1ns/1ps

module dsp_top
	import dsp_pkg::*;
#(
	parameter int accbuf_addr_w = 4
) (
	input wire dspif,
	input wire reset,
	// sequencer control and core status
	input wire stb_start,
	input wire [31:0] nshot,
	input wire [3:0] proc_done,
	input wire [3:0] elem_idle,
	// baseband sources
	input wire [sample_w-1:0] adc0,
	input wire [sample_w-1:0] adc1,
	input wire [sample_w-1:0] dac0,
	input wire [sample_w-1:0] dac1,
	input wire [sample_w-1:0] dac2,
	input wire [sample_w-1:0] dac3,
	// per lane select, lo and gate
	input wire [1:0] bb_sel0,
	input wire [1:0] bb_sel1,
	input wire [sample_w-1:0] lo_x0,
	input wire [sample_w-1:0] lo_y0,
	input wire [sample_w-1:0] lo_x1,
	input wire [sample_w-1:0] lo_y1,
	input wire gate0,
	input wire gate1,
	input wire resetacc,
	output logic proc_reset,
	output logic [31:0] shot_count,
	output logic lastshot_done,
	output logic accbuf_we0,
	output logic accbuf_we1,
	output logic [accbuf_addr_w-1:0] accbuf_addr0,
	output logic [accbuf_addr_w-1:0] accbuf_addr1,
	output logic [2*acc_w-1:0] accbuf_data0,
	output logic [2*acc_w-1:0] accbuf_data1
);

	logic [sample_w-1:0] adc0_r;
	logic [sample_w-1:0] adc1_r;
	// one bit per core folded down, all cores must agree
	logic all_done;
	logic all_idle;
	logic [acc_w-1:0] acc_x0;
	logic [acc_w-1:0] acc_y0;
	logic acc_stb0;
	logic [acc_w-1:0] acc_x1;
	logic [acc_w-1:0] acc_y1;
	logic acc_stb1;

	always_ff @(posedge dspif) begin
		adc0_r <= adc0;
		adc1_r <= adc1;
	end

	always_ff @(posedge dspif) begin
		if (reset) begin
			all_done <= 1'b0;
			all_idle <= 1'b0;
		end else begin
			all_done <= &proc_done;
			all_idle <= &elem_idle;
		end
	end

	shot_sequencer u_seq (
		.dspif(dspif),
		.reset(reset),
		.stb_start(stb_start),
		.nshot(nshot),
		.all_done(all_done),
		.all_idle(all_idle),
		.proc_reset(proc_reset),
		.shot_count(shot_count),
		.lastshot_done(lastshot_done)
	);

	// lane 0 monitors dac 0 and 1
	readout_lane u_lane0 (
		.dspif(dspif),
		.reset(reset),
		.adc(adc0_r),
		.dac_a(dac0),
		.dac_b(dac1),
		.bb_sel(bb_sel0),
		.lo_x(lo_x0),
		.lo_y(lo_y0),
		.gate(gate0),
		.acc_x(acc_x0),
		.acc_y(acc_y0),
		.acc_stb(acc_stb0)
	);

	// lane 1 monitors dac 2 and 3
	readout_lane u_lane1 (
		.dspif(dspif),
		.reset(reset),
		.adc(adc1_r),
		.dac_a(dac2),
		.dac_b(dac3),
		.bb_sel(bb_sel1),
		.lo_x(lo_x1),
		.lo_y(lo_y1),
		.gate(gate1),
		.acc_x(acc_x1),
		.acc_y(acc_y1),
		.acc_stb(acc_stb1)
	);

	accbuf_writer #(
		.accbuf_addr_w(accbuf_addr_w)
	) u_writer (
		.dspif(dspif),
		.reset(reset),
		.resetacc(resetacc),
		.acc_x0(acc_x0),
		.acc_y0(acc_y0),
		.acc_stb0(acc_stb0),
		.acc_x1(acc_x1),
		.acc_y1(acc_y1),
		.acc_stb1(acc_stb1),
		.accbuf_we0(accbuf_we0),
		.accbuf_we1(accbuf_we1),
		.accbuf_addr0(accbuf_addr0),
		.accbuf_addr1(accbuf_addr1),
		.accbuf_data0(accbuf_data0),
		.accbuf_data1(accbuf_data1)
	);

endmodule

`default_nettype wire

// ==== sim/dsp_checker.sv ====
// dsp checker: assertions on the done pulse, reset state of the cores and buffer address lock
`default_nettype none
`timescale 1ns/1ps

module dsp_checker #(
	parameter int accbuf_addr_w = 4
) (
	input wire dspif,
	input wire reset,
	input wire resetacc,
	input wire proc_reset,
	input wire lastshot_done,
	input wire accbuf_we0,
	input wire accbuf_we1,
	input wire [accbuf_addr_w-1:0] accbuf_addr0,
	input wire [accbuf_addr_w-1:0] accbuf_addr1
);

	// done is a single cycle pulse
	a_done_pulse: assert property (@(posedge dspif) disable iff (reset)
		lastshot_done |=> !lastshot_done)
		else $error("lastshot_done high for two cycles");

	// cores held in reset straight out of reset
	a_reset_cores: assert property (@(posedge dspif) reset |=> proc_reset)
		else $error("proc_reset low in the cycle after reset");

	// last location sticks, only resetacc brings it back
	a_lock0: assert property (@(posedge dspif) disable iff (reset)
		(accbuf_we0 && (&accbuf_addr0) && !resetacc) |=> (&accbuf_addr0))
		else $error("lane 0 address left the last location");

	a_lock1: assert property (@(posedge dspif) disable iff (reset)
		(accbuf_we1 && (&accbuf_addr1) && !resetacc) |=> (&accbuf_addr1))
		else $error("lane 1 address left the last location");

endmodule

bind dsp_top dsp_checker #(
	.accbuf_addr_w(accbuf_addr_w)
) u_chk (
	.dspif(dspif),
	.reset(reset),
	.resetacc(resetacc),
	.proc_reset(proc_reset),
	.lastshot_done(lastshot_done),
	.accbuf_we0(accbuf_we0),
	.accbuf_we1(accbuf_we1),
	.accbuf_addr0(accbuf_addr0),
	.accbuf_addr1(accbuf_addr1)
);

`default_nettype wire

// ==== sim/dsp_tb.sv ====
// dsp testbench checking the shot sequence, gated lane sums and buffer writes against a model
`default_nettype none
`timescale 1ns/1ps

module dsp_tb;
	import dsp_pkg::*;

	localparam int addr_w = 4;
	localparam int nshot_run = 3;
	localparam int nwin = 22;
	localparam int max_len = 32;
	// watchdog budget in clock cycles
	localparam int limit_cycles = nshot_run * 200 + nwin * 60 + 500;

	logic dspif;
	logic reset;
	logic stb_start;
	logic [31:0] nshot;
	logic [3:0] proc_done;
	logic [3:0] elem_idle;
	logic [sample_w-1:0] adc [2];
	logic [sample_w-1:0] dac [4];
	logic [1:0] bb_sel [2];
	logic [sample_w-1:0] lo_x [2];
	logic [sample_w-1:0] lo_y [2];
	logic gate [2];
	logic resetacc;
	logic proc_reset;
	logic [31:0] shot_count;
	logic lastshot_done;
	logic accbuf_we0;
	logic accbuf_we1;
	logic [addr_w-1:0] accbuf_addr0;
	logic [addr_w-1:0] accbuf_addr1;
	logic [2*acc_w-1:0] accbuf_data0;
	logic [2*acc_w-1:0] accbuf_data1;

	// samples seen by each lane while its gate was high
	// indexed by lane, source and cycle
	logic [sample_w-1:0] rec_smp [2][4][max_len];
	logic [sample_w-1:0] rec_lo_x [2][max_len];
	logic [sample_w-1:0] rec_lo_y [2][max_len];
	// expected writes per lane in order
	acc_word_t exp_word0 [$];
	acc_word_t exp_word1 [$];
	logic [addr_w-1:0] exp_addr0 [$];
	logic [addr_w-1:0] exp_addr1 [$];
	logic [addr_w-1:0] model_addr [2];
	int value_errors;
	int other_errors;
	int n_writes;

	dsp_top #(
		.accbuf_addr_w(addr_w)
	) u_dut (
		.dspif(dspif),
		.reset(reset),
		.stb_start(stb_start),
		.nshot(nshot),
		.proc_done(proc_done),
		.elem_idle(elem_idle),
		.adc0(adc[0]),
		.adc1(adc[1]),
		.dac0(dac[0]),
		.dac1(dac[1]),
		.dac2(dac[2]),
		.dac3(dac[3]),
		.bb_sel0(bb_sel[0]),
		.bb_sel1(bb_sel[1]),
		.lo_x0(lo_x[0]),
		.lo_y0(lo_y[0]),
		.lo_x1(lo_x[1]),
		.lo_y1(lo_y[1]),
		.gate0(gate[0]),
		.gate1(gate[1]),
		.resetacc(resetacc),
		.proc_reset(proc_reset),
		.shot_count(shot_count),
		.lastshot_done(lastshot_done),
		.accbuf_we0(accbuf_we0),
		.accbuf_we1(accbuf_we1),
		.accbuf_addr0(accbuf_addr0),
		.accbuf_addr1(accbuf_addr1),
		.accbuf_data0(accbuf_data0),
		.accbuf_data1(accbuf_data1)
	);

	initial dspif = 1'b0;
	always #4 dspif = ~dspif;

	// reference sums of signed 16x16 products modulo 2^32
	function automatic acc_word_t lane_sum(input int lane, input logic [1:0] sel, input int n);
		acc_word_t w;
		logic signed [acc_w-1:0] px;
		logic signed [acc_w-1:0] py;
		w.raw = '0;
		for (int k = 0; k < n; k++) begin
			px = $signed(rec_smp[lane][sel][k]) * $signed(rec_lo_x[lane][k]);
			py = $signed(rec_smp[lane][sel][k]) * $signed(rec_lo_y[lane][k]);
			w.pair.acc_x = w.pair.acc_x + px;
			w.pair.acc_y = w.pair.acc_y + py;
		end
		return w;
	endfunction

	// full scale negative drives the sums past 2^32
	function automatic logic [sample_w-1:0] draw(input bit extreme);
		if (extreme) begin
			return 16'h8000;
		end
		return sample_w'($urandom);
	endfunction

	// one gated window on both lanes with independent lengths
	task automatic run_window(input logic [1:0] sel0, input logic [1:0] sel1, input bit extreme);
		int len [2];
		int span;
		int gap;
		logic [1:0] sel [2];
		logic [sample_w-1:0] prev;
		sel[0] = sel0;
		sel[1] = sel1;
		for (int i = 0; i < 2; i++) begin
			len[i] = extreme ? 8 + $urandom_range(max_len - 8) : 1 + $urandom_range(max_len - 1);
		end
		span = (len[0] > len[1]) ? len[0] : len[1];
		for (int c = 0; c <= span; c++) begin
			@(negedge dspif);
			for (int i = 0; i < 2; i++) begin
				// adc reaches the lane one cycle late through the top level register
				prev = adc[i];
				bb_sel[i] = sel[i];
				adc[i] = draw(extreme);
				dac[2*i] = draw(extreme);
				dac[2*i+1] = draw(extreme);
				lo_x[i] = draw(extreme);
				lo_y[i] = draw(extreme);
				gate[i] = (c < len[i]);
				if (c < len[i]) begin
					rec_smp[i][0][c] = prev;
					rec_smp[i][1][c] = dac[2*i];
					rec_smp[i][2][c] = dac[2*i+1];
					rec_smp[i][3][c] = '0;
					rec_lo_x[i][c] = lo_x[i];
					rec_lo_y[i][c] = lo_y[i];
				end
				// gate just fell so the result and its address are known
				if (c == len[i]) begin
					if (i == 0) begin
						exp_word0.push_back(lane_sum(0, sel[0], len[0]));
						exp_addr0.push_back(model_addr[0]);
					end else begin
						exp_word1.push_back(lane_sum(1, sel[1], len[1]));
						exp_addr1.push_back(model_addr[1]);
					end
					if (model_addr[i] != '1) begin
						model_addr[i] = model_addr[i] + 1'b1;
					end
				end
			end
		end
		gap = 1 + $urandom_range(3);
		repeat (gap) @(negedge dspif);
	endtask

	task automatic check_write(input int lane, input logic [addr_w-1:0] addr, input acc_word_t got);
		acc_word_t exp;
		logic [addr_w-1:0] exp_a;
		if ((lane == 0 && exp_word0.size() == 0) || (lane == 1 && exp_word1.size() == 0)) begin
			$display("lane %0d wrote to the buffer at %0t with no result pending", lane, $time);
			other_errors++;
		end else begin
			if (lane == 0) begin
				exp = exp_word0.pop_front();
				exp_a = exp_addr0.pop_front();
			end else begin
				exp = exp_word1.pop_front();
				exp_a = exp_addr1.pop_front();
			end
			n_writes++;
			if (addr !== exp_a) begin
				$display("ERROR %0t: lane %0d address %0d, expected %0d", $time, lane, addr, exp_a);
				value_errors++;
			end
			if (got.pair.acc_x !== exp.pair.acc_x) begin
				$display("ERROR %0t: lane %0d acc_x %h, expected %h",
					$time, lane, got.pair.acc_x, exp.pair.acc_x);
				value_errors++;
			end
			if (got.pair.acc_y !== exp.pair.acc_y) begin
				$display("ERROR %0t: lane %0d acc_y %h, expected %h",
					$time, lane, got.pair.acc_y, exp.pair.acc_y);
				value_errors++;
			end
		end
	endtask

	// registered outputs are stable at the falling edge
	always @(negedge dspif) begin
		if (accbuf_we0 === 1'b1) begin
			check_write(0, accbuf_addr0, accbuf_data0);
		end
		if (accbuf_we1 === 1'b1) begin
			check_write(1, accbuf_addr1, accbuf_data1);
		end
	end

	// multi shot run with the bench playing the cores and elements
	task automatic run_shots(input int n);
		int lows;
		int pulses;
		int hold_done;
		int hold_idle;
		int tail;
		logic prev_rst;
		logic [31:0] counts [$];
		lows = 0;
		pulses = 0;
		hold_done = -1;
		hold_idle = -1;
		tail = -1;
		@(negedge dspif);
		nshot = n;
		@(negedge dspif);
		stb_start = 1'b1;
		@(negedge dspif);
		stb_start = 1'b0;
		prev_rst = proc_reset;
		while (tail != 0) begin
			@(negedge dspif);
			// cores released and elements busy until the drain
			if (prev_rst && !proc_reset) begin
				lows++;
				elem_idle = 4'h0;
				hold_done = 2 + $urandom_range(6);
			end
			// cores back in reset drop their done flags
			if (!prev_rst && proc_reset) begin
				proc_done = 4'h0;
				hold_idle = 1 + $urandom_range(5);
			end
			if (hold_done == 0) begin
				proc_done = 4'hf;
			end
			if (hold_done >= 0) begin
				hold_done--;
			end
			if (hold_idle == 0) begin
				elem_idle = 4'hf;
			end
			if (hold_idle >= 0) begin
				hold_idle--;
			end
			if (counts.size() == 0 || counts[$] != shot_count) begin
				counts.push_back(shot_count);
			end
			if (lastshot_done) begin
				pulses++;
				if (lows != n || !proc_reset) begin
					$display("ERROR %0t: lastshot_done after %0d runs, expected %0d", $time, lows, n);
					value_errors++;
				end
				tail = 40;
			end
			if (tail > 0) begin
				tail--;
			end
			prev_rst = proc_reset;
		end
		if (lows != n) begin
			$display("ERROR %0t: %0d proc_reset low windows, expected %0d", $time, lows, n);
			value_errors++;
		end
		if (pulses != 1) begin
			$display("ERROR %0t: %0d lastshot_done pulses, expected 1", $time, pulses);
			value_errors++;
		end
		if (counts.size() != n) begin
			$display("ERROR %0t: shot_count took %0d values, expected %0d", $time, counts.size(), n);
			value_errors++;
		end else begin
			for (int k = 0; k < n; k++) begin
				if (counts[k] != k) begin
					$display("ERROR %0t: shot_count step %0d is %0d", $time, k, counts[k]);
					value_errors++;
				end
			end
		end
		elem_idle = 4'h0;
	endtask

	task automatic drain_writes();
		while (exp_word0.size() != 0 || exp_word1.size() != 0) begin
			@(negedge dspif);
		end
		repeat (4) @(negedge dspif);
	endtask

	initial begin
		void'($urandom(32'hf7561fde));
		value_errors = 0;
		other_errors = 0;
		n_writes = 0;
		reset = 1'b1;
		stb_start = 1'b0;
		nshot = 32'd0;
		proc_done = 4'h0;
		elem_idle = 4'h0;
		resetacc = 1'b0;
		for (int i = 0; i < 2; i++) begin
			adc[i] = '0;
			bb_sel[i] = src_adc;
			lo_x[i] = '0;
			lo_y[i] = '0;
			gate[i] = 1'b0;
			model_addr[i] = '0;
		end
		for (int i = 0; i < 4; i++) begin
			dac[i] = '0;
		end
		repeat (5) @(negedge dspif);
		reset = 1'b0;
		@(negedge dspif);
		if (proc_reset !== 1'b1 || lastshot_done !== 1'b0) begin
			$display("ERROR %0t: sequencer outputs wrong after reset", $time);
			value_errors++;
		end
		if (accbuf_we0 !== 1'b0 || accbuf_we1 !== 1'b0 || accbuf_addr0 !== '0 || accbuf_addr1 !== '0) begin
			$display("ERROR %0t: buffer ports wrong after reset", $time);
			value_errors++;
		end
		run_shots(nshot_run);
		// every real source on both lanes
		for (int s = 0; s < 3; s++) begin
			repeat (4) run_window(2'(s), 2'((s + 1) % 3), 1'b0);
		end
		run_window(src_dac_a, src_adc, 1'b1);
		run_window(src_adc, src_dac_b, 1'b1);
		repeat (2) run_window(src_zero, src_zero, 1'b0);
		// addresses are locked at the top by now
		repeat (3) run_window(2'($urandom_range(3)), 2'($urandom_range(3)), 1'b0);
		drain_writes();
		@(negedge dspif);
		resetacc = 1'b1;
		@(negedge dspif);
		resetacc = 1'b0;
		repeat (2) @(negedge dspif);
		model_addr[0] = '0;
		model_addr[1] = '0;
		repeat (3) run_window(2'($urandom_range(2)), 2'($urandom_range(2)), 1'b0);
		drain_writes();
		if (n_writes != 2 * nwin) begin
			$display("only %0d of %0d buffer writes were seen", n_writes, 2 * nwin);
			other_errors++;
		end
		$display("writes checked %0d, value errors %0d, other errors %0d",
			n_writes, value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	// hang guard
	initial begin
		repeat (limit_cycles) @(posedge dspif);
		$display("timeout: the run did not finish within %0d cycles", limit_cycles);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== project.f ====
logic/dsp_pkg.sv
logic/shot_sequencer.sv
logic/readout_lane.sv
logic/accbuf_writer.sv
logic/dsp_top.sv
sim/dsp_checker.sv
sim/dsp_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the dsp testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module dsp_tb -f project.f -o dsp_sim

# an assertion stop ends the run early, the log decides
./obj_dir/dsp_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION FAILED" sim.log || ! grep -q "SIMULATION PASSED" sim.log; then
	exit 1
fi
exit 0
